/* hw/integ_pkg.sv */
/*
 * Shared types and constants for the feature integration controller:
 * status and control structs, thresholds, sequencer states, debug request
 */

package integ_pkg;

    // ==============================
    // Limits and thresholds
    // ==============================
    localparam int NUM_CORES_MAX       = 8;
    localparam int QOS_VIOLATION_LIMIT = 100;
    localparam int THROTTLE_THRESHOLD  = 80;

    // Debug register file geometry
    localparam int DBG_WORDS    = 16;
    localparam int DBG_RO_WORDS = 4;

    // ==============================
    // Raw status from the cores
    // ==============================
    // Per-core vectors, cores above NUM_CORES tied low
    typedef struct packed {
        logic [NUM_CORES_MAX-1:0] rob_full;
        logic [NUM_CORES_MAX-1:0] rs_full;
        logic [NUM_CORES_MAX-1:0] dispatch_stall;
    } ooo_status_s;

    typedef struct packed {
        logic [7:0]  bandwidth_util;
        logic [15:0] violations;
    } qos_status_s;

    // Protocol 0 means no protocol active
    typedef struct packed {
        logic [2:0] protocol;
        logic       switching;
    } proto_status_s;

    // Registered healthy flags plus combinational stress terms
    typedef struct packed {
        logic ooo_healthy;
        logic qos_healthy;
        logic debug_healthy;
        logic proto_healthy;
        logic ooo_throttle_needed;
        logic qos_intervene_needed;
        logic stress;
    } health_s;

    // ==============================
    // Control outputs
    // ==============================
    typedef struct packed {
        logic [3:0] rob_throttle;
        logic [2:0] dispatch_policy;
        logic [7:0] qos_mask;
        logic [7:0] bw_limit;
    } ctrl_s;

    // No throttling, balanced policy, all levels, no limit
    localparam ctrl_s ctrl_reset = '{
        rob_throttle:    4'b1111,
        dispatch_policy: 3'b001,
        qos_mask:        8'hFF,
        bw_limit:        8'hFF
    };

    // Bit 0 is ooo, bit 3 is protocol
    typedef struct packed {
        logic proto_integrated;
        logic debug_integrated;
        logic qos_integrated;
        logic ooo_integrated;
    } integ_status_s;

    typedef enum logic [2:0] {
        INIT      = 3'd0,
        SCAN      = 3'd1,
        INTEGRATE = 3'd2,
        MONITOR   = 3'd3,
        OPTIMIZE  = 3'd4
    } seq_state_e;

    typedef struct packed {
        logic                         write;
        logic [$clog2(DBG_WORDS)-1:0] addr;
        logic [31:0]                  wdata;
    } dbg_req_s;

endpackage

/* hw/health_monitor.sv */
/*
 * Decode stage: registered health flags, combinational stress terms
 * and the weighted health score
 */

`timescale 1ns/1ns

module health_monitor
    import integ_pkg::*;
#(
    parameter int NUM_CORES = 4
) (
    input  logic          clk_i,
    input  logic          rst_ni,
    input  ooo_status_s   ooo_i,
    input  qos_status_s   qos_i,
    input  proto_status_s proto_i,
    input  logic          features_en_i,
    output health_s       health_o,
    output logic [7:0]    score_o
);

    // Only the populated cores count
    localparam logic [NUM_CORES_MAX-1:0] CORE_MASK =
        {NUM_CORES_MAX{1'b1}} >> (NUM_CORES_MAX - NUM_CORES);

    logic [NUM_CORES_MAX-1:0] rob_full_m;
    logic [NUM_CORES_MAX-1:0] rs_full_m;
    logic [NUM_CORES_MAX-1:0] stall_m;

    logic ooo_healthy_q;
    logic qos_healthy_q;
    logic debug_healthy_q;
    logic proto_healthy_q;

    logic throttle_needed;
    logic intervene_needed;

    logic [7:0] ooo_score;
    logic [7:0] qos_score;
    logic [7:0] debug_score;
    logic [7:0] proto_score;
    logic [9:0] score_sum;

    assign rob_full_m = ooo_i.rob_full & CORE_MASK;
    assign rs_full_m  = ooo_i.rs_full & CORE_MASK;
    assign stall_m    = ooo_i.dispatch_stall & CORE_MASK;

    // ==============================
    // Health flags, one cycle late
    // ==============================
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ooo_healthy_q   <= 1'b0;
            qos_healthy_q   <= 1'b0;
            debug_healthy_q <= 1'b0;
            proto_healthy_q <= 1'b0;
        end else begin
            // Unhealthy only when ROB and RS are both backed up
            ooo_healthy_q   <= !((|rob_full_m) && (|rs_full_m));
            qos_healthy_q   <= (qos_i.violations < 16'(QOS_VIOLATION_LIMIT));
            debug_healthy_q <= features_en_i;
            proto_healthy_q <= (proto_i.protocol != 3'd0);
        end
    end

    // Stress terms follow the current inputs
    assign throttle_needed  = (|rob_full_m) || (|stall_m);
    assign intervene_needed = (qos_i.violations > 16'(QOS_VIOLATION_LIMIT)) ||
                              (qos_i.bandwidth_util > 8'(THROTTLE_THRESHOLD));

    always_comb begin
        health_o.ooo_healthy          = ooo_healthy_q;
        health_o.qos_healthy          = qos_healthy_q;
        health_o.debug_healthy        = debug_healthy_q;
        health_o.proto_healthy        = proto_healthy_q;
        health_o.ooo_throttle_needed  = throttle_needed;
        health_o.qos_intervene_needed = intervene_needed;
        health_o.stress = throttle_needed || intervene_needed || proto_i.switching;
    end

    // ==============================
    // Weighted score
    // ==============================
    always_comb begin
        ooo_score   = !ooo_healthy_q   ? 8'd100 : (throttle_needed   ? 8'd180 : 8'd255);
        qos_score   = !qos_healthy_q   ? 8'd80  : (intervene_needed  ? 8'd160 : 8'd255);
        debug_score = !debug_healthy_q ? 8'd120 : 8'd255;
        proto_score = !proto_healthy_q ? 8'd60  : (proto_i.switching ? 8'd200 : 8'd255);
        // Average of four, remainder dropped
        score_sum = 10'(ooo_score) + 10'(qos_score) + 10'(debug_score) + 10'(proto_score);
        score_o   = score_sum[9:2];
    end

endmodule

/* hw/throttle_ctrl.sv */
/*
 * Execute stage: registered ROB throttle, dispatch policy,
 * QoS priority mask and bandwidth limit
 */

`timescale 1ns/1ns

module throttle_ctrl
    import integ_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_ni,
    input  ooo_status_s ooo_i,
    input  health_s     health_i,
    output ctrl_s       ctrl_o
);

    // Throttle and policy encodings
    localparam logic [3:0] THROTTLE_FULL       = 4'b1111;
    localparam logic [3:0] THROTTLE_HALF       = 4'b0111;
    localparam logic [2:0] POLICY_BALANCED     = 3'b001;
    localparam logic [2:0] POLICY_CONSERVATIVE = 3'b010;

    // Half bandwidth, top priority level masked off
    localparam logic [7:0] BW_LIMIT_HALF = 8'h80;
    localparam logic [7:0] BW_LIMIT_NONE = 8'hFF;
    localparam logic [7:0] MASK_ALL      = 8'hFF;

    ctrl_s ctrl_d;
    ctrl_s ctrl_q;

    // ==============================
    // Next control values
    // ==============================
    always_comb begin
        ctrl_d = ctrl_reset;

        // ROB and dispatch
        if (health_i.ooo_throttle_needed) begin
            ctrl_d.dispatch_policy = POLICY_CONSERVATIVE;
            // Halve the window only when a ROB is actually full
            ctrl_d.rob_throttle = (|ooo_i.rob_full) ? THROTTLE_HALF : THROTTLE_FULL;
        end else begin
            ctrl_d.dispatch_policy = POLICY_BALANCED;
            ctrl_d.rob_throttle    = THROTTLE_FULL;
        end

        // Memory QoS
        if (health_i.qos_intervene_needed) begin
            ctrl_d.bw_limit = BW_LIMIT_HALF;
            ctrl_d.qos_mask = MASK_ALL >> 1;
        end else begin
            ctrl_d.bw_limit = BW_LIMIT_NONE;
            ctrl_d.qos_mask = MASK_ALL;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ctrl_q <= ctrl_reset;
        end else begin
            ctrl_q <= ctrl_d;
        end
    end

    assign ctrl_o = ctrl_q;

endmodule

/* hw/integ_sequencer.sv */
/*
 * Integration FSM: init wait, scan, integrate, monitor, optimize
 * Tracks per-feature integration status and completion
 */

`timescale 1ns/1ns

module integ_sequencer
    import integ_pkg::*;
#(
    parameter int INIT_CYCLES = 100
) (
    input  logic          clk_i,
    input  logic          rst_ni,
    input  health_s       health_i,
    output logic          features_en_o,
    output logic          complete_o,
    output integ_status_s status_o
);

    // Counter must reach INIT_CYCLES + 1
    localparam int CNT_W = $clog2(INIT_CYCLES + 2);

    seq_state_e       state_q;
    seq_state_e       state_d;
    logic [CNT_W-1:0] init_cnt_q;
    integ_status_s    status_q;
    logic             all_healthy;

    assign all_healthy = health_i.ooo_healthy && health_i.qos_healthy &&
                         health_i.debug_healthy && health_i.proto_healthy;

    // ==============================
    // State and init counter
    // ==============================
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= INIT;
            init_cnt_q <= '0;
        end else begin
            state_q <= state_d;
            // Stops counting once out of INIT
            if (state_q == INIT) begin
                init_cnt_q <= init_cnt_q + 1'b1;
            end
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            INIT: begin
                if (init_cnt_q > CNT_W'(INIT_CYCLES)) begin
                    state_d = SCAN;
                end
            end
            // Single cycle
            SCAN:      state_d = INTEGRATE;
            INTEGRATE: begin
                if (all_healthy) begin
                    state_d = MONITOR;
                end
            end
            MONITOR: begin
                if (health_i.stress) begin
                    state_d = OPTIMIZE;
                end
            end
            OPTIMIZE: begin
                if (!health_i.stress) begin
                    state_d = MONITOR;
                end
            end
            default:   state_d = INIT;
        endcase
    end

    // ==============================
    // Integration status
    // ==============================
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            status_q <= '0;
        end else if (state_q == INTEGRATE) begin
            status_q.ooo_integrated   <= health_i.ooo_healthy;
            status_q.qos_integrated   <= health_i.qos_healthy;
            status_q.debug_integrated <= health_i.debug_healthy;
            status_q.proto_integrated <= health_i.proto_healthy;
        end else if (state_q == MONITOR || state_q == OPTIMIZE) begin
            // Flags only drop here, never come back
            status_q.ooo_integrated   <= status_q.ooo_integrated && health_i.ooo_healthy;
            status_q.qos_integrated   <= status_q.qos_integrated && health_i.qos_healthy;
            status_q.debug_integrated <= status_q.debug_integrated && health_i.debug_healthy;
            status_q.proto_integrated <= status_q.proto_integrated && health_i.proto_healthy;
        end
    end

    // Features off until integration starts
    assign features_en_o = (state_q == INTEGRATE) || (state_q == MONITOR) ||
                           (state_q == OPTIMIZE);
    // Still integrated while optimizing
    assign complete_o    = ((state_q == MONITOR) && all_healthy) || (state_q == OPTIMIZE);
    assign status_o      = status_q;

endmodule

/* hw/debug_regfile.sv */
/*
 * Result stage: 16-word debug register file, words 0 to 3 are status
 * snapshots, one-deep valid/ready request and response handshake
 */

`timescale 1ns/1ns

module debug_regfile
    import integ_pkg::*;
(
    input  logic          clk_i,
    input  logic          rst_ni,
    input  logic          features_en_i,
    input  logic [7:0]    score_i,
    input  integ_status_s status_i,
    input  ctrl_s         ctrl_i,
    input  logic          req_valid_i,
    input  dbg_req_s      req_i,
    output logic          req_ready_o,
    output logic          rsp_valid_o,
    output logic [31:0]   rsp_data_o,
    input  logic          rsp_ready_i
);

    logic [31:0] words_q [DBG_WORDS];
    logic        rsp_valid_q;
    logic [31:0] rsp_data_q;
    logic        accept;
    logic        wr_allowed;

    // One response in flight at most
    assign req_ready_o = features_en_i && !rsp_valid_q;
    assign accept      = req_valid_i && req_ready_o;
    // Snapshot words are read only
    assign wr_allowed  = req_i.write && (req_i.addr >= DBG_RO_WORDS);

    // ==============================
    // Register storage
    // ==============================
    always_ff @(posedge clk_i) begin
        // Status snapshots, refreshed each cycle
        words_q[0] <= {24'd0, score_i};
        words_q[1] <= {28'd0, status_i};
        words_q[2] <= {28'd0, ctrl_i.rob_throttle};
        words_q[3] <= {24'd0, ctrl_i.bw_limit};

        if (accept && wr_allowed) begin
            words_q[req_i.addr] <= req_i.wdata;
        end
    end

    // ==============================
    // Response handshake
    // ==============================
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rsp_valid_q <= 1'b0;
        end else if (accept) begin
            rsp_valid_q <= 1'b1;
        end else if (rsp_valid_q && rsp_ready_i) begin
            rsp_valid_q <= 1'b0;
        end
    end

    // Data loaded at acceptance, held under back-pressure
    always_ff @(posedge clk_i) begin
        if (accept) begin
            // Writes echo their data; ignored writes return the old word
            rsp_data_q <= wr_allowed ? req_i.wdata : words_q[req_i.addr];
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_data_o  = rsp_data_q;

endmodule

/* hw/feature_integrator.sv */
/*
 * Top level of the feature integration controller
 * Health decode, control registers, sequencer and debug register file
 */

`timescale 1ns/1ns

module feature_integrator
    import integ_pkg::*;
#(
    parameter int NUM_CORES   = 4,
    parameter int INIT_CYCLES = 100
) (
    input  logic          clk_i,
    input  logic          rst_ni,
    // Core, memory and protocol status
    input  ooo_status_s   ooo_i,
    input  qos_status_s   qos_i,
    input  proto_status_s proto_i,
    // Debug access
    input  logic          dbg_req_valid_i,
    input  dbg_req_s      dbg_req_i,
    output logic          dbg_req_ready_o,
    output logic          dbg_rsp_valid_o,
    output logic [31:0]   dbg_rsp_data_o,
    input  logic          dbg_rsp_ready_i,
    // Integration results
    output logic          complete_o,
    output logic [7:0]    score_o,
    output integ_status_s status_o,
    output ctrl_s         ctrl_o,
    output logic          features_en_o
);

    health_s       health;
    logic [7:0]    score;
    logic          features_en;
    integ_status_s status;
    ctrl_s         ctrl;

    // ==============================
    // Decode and execute
    // ==============================
    health_monitor #(
        .NUM_CORES(NUM_CORES)
    ) i_health_monitor (
        .clk_i,
        .rst_ni,
        .ooo_i,
        .qos_i,
        .proto_i,
        .features_en_i(features_en),
        .health_o     (health),
        .score_o      (score)
    );

    throttle_ctrl i_throttle_ctrl (
        .clk_i,
        .rst_ni,
        .ooo_i,
        .health_i(health),
        .ctrl_o  (ctrl)
    );

    // Sequencing
    integ_sequencer #(
        .INIT_CYCLES(INIT_CYCLES)
    ) i_integ_sequencer (
        .clk_i,
        .rst_ni,
        .health_i     (health),
        .features_en_o(features_en),
        .complete_o   (complete_o),
        .status_o     (status)
    );

    // ==============================
    // Debug access
    // ==============================
    debug_regfile i_debug_regfile (
        .clk_i,
        .rst_ni,
        .features_en_i(features_en),
        .score_i      (score),
        .status_i     (status),
        .ctrl_i       (ctrl),
        .req_valid_i  (dbg_req_valid_i),
        .req_i        (dbg_req_i),
        .req_ready_o  (dbg_req_ready_o),
        .rsp_valid_o  (dbg_rsp_valid_o),
        .rsp_data_o   (dbg_rsp_data_o),
        .rsp_ready_i  (dbg_rsp_ready_i)
    );

    assign score_o       = score;
    assign status_o      = status;
    assign ctrl_o        = ctrl;
    assign features_en_o = features_en;

endmodule

/* dv/tb_feature_integrator.sv */
/*
 * Directed testbench for the feature integration controller
 * Clock and reset, stimulus and debug tasks, reference score rule, summary
 */

`timescale 1ns/1ns

module tb_feature_integrator
    import integ_pkg::*;
();

    localparam int NUM_CORES       = 4;
    localparam int INIT_CYCLES     = 20;
    localparam int BRINGUP_TIMEOUT = 60;
    localparam int HS_TIMEOUT      = 20;

    // Quiet cores, light memory traffic, protocol 1 active
    localparam ooo_status_s   OOO_IDLE   = '0;
    localparam qos_status_s   QOS_NORMAL = '{bandwidth_util: 8'd40, violations: 16'd3};
    localparam proto_status_s PROTO_UP   = '{protocol: 3'd1, switching: 1'b0};

    logic          clk = 1'b0;
    logic          rst_n;
    ooo_status_s   ooo;
    qos_status_s   qos;
    proto_status_s proto;
    logic          dbg_req_valid;
    dbg_req_s      dbg_req;
    logic          dbg_req_ready;
    logic          dbg_rsp_valid;
    logic [31:0]   dbg_rsp_data;
    logic          dbg_rsp_ready;
    logic          complete;
    logic [7:0]    score;
    integ_status_s status;
    ctrl_s         ctrl;
    logic          features_en;

    int            errors = 0;
    int            tests  = 0;
    integer        seed   = 32'h31f79155;
    // Integration status the rules predict
    logic [3:0]    exp_status;

    always #10 clk = ~clk;

    feature_integrator #(
        .NUM_CORES  (NUM_CORES),
        .INIT_CYCLES(INIT_CYCLES)
    ) i_feature_integrator (
        .clk_i          (clk),
        .rst_ni         (rst_n),
        .ooo_i          (ooo),
        .qos_i          (qos),
        .proto_i        (proto),
        .dbg_req_valid_i(dbg_req_valid),
        .dbg_req_i      (dbg_req),
        .dbg_req_ready_o(dbg_req_ready),
        .dbg_rsp_valid_o(dbg_rsp_valid),
        .dbg_rsp_data_o (dbg_rsp_data),
        .dbg_rsp_ready_i(dbg_rsp_ready),
        .complete_o     (complete),
        .score_o        (score),
        .status_o       (status),
        .ctrl_o         (ctrl),
        .features_en_o  (features_en)
    );

    // ==============================
    // Reference rule and helpers
    // ==============================
    // Steady-state score, health flags assumed settled on the current inputs
    function automatic logic [7:0] expected_score(input ooo_status_s o, input qos_status_s q,
                                                  input proto_status_s p, input logic dbg_ok);
        logic [NUM_CORES_MAX-1:0] used;
        logic                     rob_any;
        logic                     rs_any;
        logic                     stall_any;
        logic                     intervene;
        int                       sum;
        used = '0;
        for (int c = 0; c < NUM_CORES; c++) begin
            used[c] = 1'b1;
        end
        rob_any   = |(o.rob_full & used);
        rs_any    = |(o.rs_full & used);
        stall_any = |(o.dispatch_stall & used);
        intervene = (q.violations > 16'd100) || (q.bandwidth_util > 8'd80);
        sum = (rob_any && rs_any) ? 100 : ((rob_any || stall_any) ? 180 : 255);
        sum += (q.violations >= 16'd100) ? 80 : (intervene ? 160 : 255);
        sum += dbg_ok ? 255 : 120;
        sum += (p.protocol == 3'd0) ? 60 : (p.switching ? 200 : 255);
        return 8'(sum / 4);
    endfunction

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int start);
        tests++;
        $display("test %s finished with %0d failed checks", name, errors - start);
    endtask

    // New inputs on a rising edge
    task automatic apply_inputs(input ooo_status_s o, input qos_status_s q,
                                input proto_status_s p);
        @(posedge clk);
        ooo   <= o;
        qos   <= q;
        proto <= p;
    endtask

    // Sample n cycles after the drive edge, away from the clock edge
    task automatic settle(input int n);
        repeat (n) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic wait_complete(input int limit);
        int cnt;
        cnt = 0;
        while (!complete && cnt < limit) begin
            @(negedge clk);
            cnt++;
        end
        assert (complete) else begin
            $display("Timeout: complete_o still low after %0d cycles", limit);
            errors++;
        end
    endtask

    // One debug request, returns once the response is valid
    task automatic issue_req(input logic wr_en, input logic [3:0] word,
                             input logic [31:0] data, output logic [31:0] rdata);
        int   cnt;
        logic seen;
        @(posedge clk);
        dbg_req_valid <= 1'b1;
        dbg_req       <= '{write: wr_en, addr: word, wdata: data};
        cnt  = 0;
        seen = 1'b0;
        while (!seen && cnt < HS_TIMEOUT) begin
            @(negedge clk);
            seen = dbg_req_ready;
            cnt++;
        end
        assert (seen) else begin
            $display("Timeout: dbg_req_ready_o never rose for word %0d", word);
            errors++;
        end
        // Transfer on this edge
        @(posedge clk);
        dbg_req_valid <= 1'b0;
        cnt  = 0;
        seen = 1'b0;
        while (!seen && cnt < HS_TIMEOUT) begin
            @(negedge clk);
            seen = dbg_rsp_valid;
            cnt++;
        end
        assert (seen) else begin
            $display("Timeout: no debug response for word %0d", word);
            errors++;
        end
        check_equal("dbg_rsp_valid_o latency", cnt, 1);
        rdata = dbg_rsp_data;
    endtask

    task automatic wait_rsp_done();
        int cnt;
        cnt = 0;
        while (dbg_rsp_valid && cnt < HS_TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        assert (!dbg_rsp_valid) else begin
            $display("Timeout: debug response was never taken");
            errors++;
        end
    endtask

    // ==============================
    // Directed tests
    // ==============================
    task automatic test_bringup();
        int start;
        start = errors;
        @(negedge clk);
        check_equal("ctrl_o", ctrl, ctrl_reset);
        check_equal("features_en_o", features_en, 1'b0);
        check_equal("complete_o", complete, 1'b0);
        check_equal("dbg_req_ready_o", dbg_req_ready, 1'b0);
        check_equal("dbg_rsp_valid_o", dbg_rsp_valid, 1'b0);
        wait_complete(BRINGUP_TIMEOUT);
        exp_status = 4'b1111;
        check_equal("status_o", status, exp_status);
        check_equal("features_en_o", features_en, 1'b1);
        check_equal("score_o", score, expected_score(ooo, qos, proto, 1'b1));
        finish_test("bringup", start);
    endtask

    task automatic test_throttle();
        int          start;
        ooo_status_s o;
        start = errors;
        o = OOO_IDLE;
        o.rob_full[1] = 1'b1;
        apply_inputs(o, QOS_NORMAL, PROTO_UP);
        settle(1);
        check_equal("ctrl_o.rob_throttle", ctrl.rob_throttle, 4'b0111);
        check_equal("ctrl_o.dispatch_policy", ctrl.dispatch_policy, 3'b010);
        check_equal("score_o", score, expected_score(ooo, qos, proto, 1'b1));
        // Stall alone keeps the full window
        o = OOO_IDLE;
        o.dispatch_stall[2] = 1'b1;
        apply_inputs(o, QOS_NORMAL, PROTO_UP);
        settle(1);
        check_equal("ctrl_o.rob_throttle", ctrl.rob_throttle, 4'b1111);
        check_equal("ctrl_o.dispatch_policy", ctrl.dispatch_policy, 3'b010);
        check_equal("score_o", score, expected_score(ooo, qos, proto, 1'b1));
        apply_inputs(OOO_IDLE, QOS_NORMAL, PROTO_UP);
        settle(1);
        check_equal("ctrl_o.rob_throttle", ctrl.rob_throttle, 4'b1111);
        check_equal("ctrl_o.dispatch_policy", ctrl.dispatch_policy, 3'b001);
        check_equal("score_o", score, expected_score(ooo, qos, proto, 1'b1));
        finish_test("throttle", start);
    endtask

    task automatic test_qos();
        int          start;
        qos_status_s q;
        start = errors;
        q = QOS_NORMAL;
        q.bandwidth_util = 8'd90;
        apply_inputs(OOO_IDLE, q, PROTO_UP);
        settle(1);
        check_equal("ctrl_o.bw_limit", ctrl.bw_limit, 8'h80);
        check_equal("ctrl_o.qos_mask", ctrl.qos_mask, 8'h7F);
        check_equal("score_o", score, expected_score(ooo, qos, proto, 1'b1));
        apply_inputs(OOO_IDLE, QOS_NORMAL, PROTO_UP);
        settle(1);
        check_equal("ctrl_o", ctrl, ctrl_reset);
        check_equal("score_o", score, expected_score(ooo, qos, proto, 1'b1));
        finish_test("qos", start);
    endtask

    task automatic test_health_loss();
        int            start;
        proto_status_s p;
        start = errors;
        p = PROTO_UP;
        p.protocol = 3'd0;
        apply_inputs(OOO_IDLE, QOS_NORMAL, p);
        // Flag drops after one cycle, status one cycle later
        settle(3);
        exp_status[3] = 1'b0;
        check_equal("complete_o", complete, 1'b0);
        check_equal("status_o", status, exp_status);
        check_equal("score_o", score, expected_score(ooo, qos, proto, 1'b1));
        // Completion returns, the lost status flag does not
        apply_inputs(OOO_IDLE, QOS_NORMAL, PROTO_UP);
        wait_complete(HS_TIMEOUT);
        check_equal("status_o", status, exp_status);
        check_equal("score_o", score, expected_score(ooo, qos, proto, 1'b1));
        finish_test("health_loss", start);
    endtask

    task automatic test_debug();
        int          start;
        logic [31:0] exp_words [DBG_WORDS];
        logic [31:0] rdata;
        logic [31:0] held;
        logic [31:0] wdata;
        start = errors;
        // Snapshot words predicted for the present steady state
        exp_words[0] = 32'(expected_score(ooo, qos, proto, 1'b1));
        exp_words[1] = {28'd0, exp_status};
        exp_words[2] = 32'h0000_000F;
        exp_words[3] = 32'h0000_00FF;
        for (int w = DBG_RO_WORDS; w < DBG_WORDS; w++) begin
            wdata = $random(seed);
            exp_words[w] = wdata;
            issue_req(1'b1, 4'(w), wdata, rdata);
            wait_rsp_done();
            check_equal("dbg_rsp_data_o", rdata, wdata);
        end
        for (int w = 0; w < DBG_WORDS; w++) begin
            // Protected words answer with their old value
            if (w < DBG_RO_WORDS) begin
                wdata = $random(seed);
                issue_req(1'b1, 4'(w), wdata, rdata);
                wait_rsp_done();
                check_equal("dbg_rsp_data_o", rdata, exp_words[w]);
            end
            issue_req(1'b0, 4'(w), 32'd0, rdata);
            wait_rsp_done();
            check_equal("dbg_rsp_data_o", rdata, exp_words[w]);
        end
        // Back-pressure on the response
        @(posedge clk);
        dbg_rsp_ready <= 1'b0;
        issue_req(1'b0, 4'd7, 32'd0, held);
        check_equal("dbg_rsp_data_o", held, exp_words[7]);
        // A second request waits while the response is pending
        wdata = $random(seed);
        @(posedge clk);
        dbg_req_valid <= 1'b1;
        dbg_req       <= '{write: 1'b1, addr: 4'd8, wdata: wdata};
        repeat (5) begin
            @(negedge clk);
            check_equal("dbg_rsp_valid_o", dbg_rsp_valid, 1'b1);
            check_equal("dbg_rsp_data_o", dbg_rsp_data, held);
            check_equal("dbg_req_ready_o", dbg_req_ready, 1'b0);
        end
        @(posedge clk);
        dbg_req_valid <= 1'b0;
        dbg_rsp_ready <= 1'b1;
        wait_rsp_done();
        // Word 8 untouched by the blocked write
        issue_req(1'b0, 4'd8, 32'd0, rdata);
        wait_rsp_done();
        check_equal("dbg_rsp_data_o", rdata, exp_words[8]);
        finish_test("debug", start);
    endtask

    initial begin
        rst_n         <= 1'b0;
        ooo           <= OOO_IDLE;
        qos           <= QOS_NORMAL;
        proto         <= PROTO_UP;
        dbg_req_valid <= 1'b0;
        dbg_req       <= '0;
        dbg_rsp_ready <= 1'b1;
        exp_status    = 4'b0000;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        test_bringup();
        test_throttle();
        test_qos();
        test_health_loss();
        test_debug();

        $display("summary: %0d tests run, %0d failed checks", tests, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* list.f */
hw/integ_pkg.sv
hw/health_monitor.sv
hw/throttle_ctrl.sv
hw/integ_sequencer.sv
hw/debug_regfile.sv
hw/feature_integrator.sv
dv/tb_feature_integrator.sv

/* Makefile */
# Verilator build, run, lint and clean for the feature integration controller

VERILATOR  ?= verilator
TOP        ?= tb_feature_integrator
DUT_TOP    ?= feature_integrator
FILELIST   ?= list.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= ERRORS FOUND
VFLAGS     ?= --binary --timing -j 0 -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall

SRCS     := $(shell cat $(FILELIST))
RTL_SRCS := $(filter hw/%,$(SRCS))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(DUT_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
